/* all.f */
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/fetch_line_cache.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
tb/fetch_assertions.sv
tb/fetch_tb.sv

/* tb/fetch_tb.sv */
// ========================================
// Testbench for the fetch front end
// Plays a table of rows, one per clock, into the top level and
// checks each bundle against a reference model of the fetch rules
// ========================================
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

	localparam fetch_pkg::addr_t RST_PC = 32'h0000_1000;
	localparam int unsigned LINES = 8;
	localparam int unsigned WARMUP = 4;
	localparam int NROWS = 21;
	// Eight ns per row with a factor of four in hand
	localparam int WATCHDOG_NS = 8 * NROWS * 4;

	// Inputs applied in one cycle
	// Fill data is drawn separately from the seed
	typedef struct packed {
		logic en;
		logic stall;
		logic redirect;
		fetch_pkg::addr_t redirect_pc;
		logic fill;
		fetch_pkg::addr_t fill_adr;
		logic nmi;
		logic stomp;
		fetch_pkg::bno_t stomp_bno;
		logic mc_active;
		fetch_pkg::addr_t mc_adr;
		fetch_pkg::uop_t uop_num;
	} row_t;

	logic clk = 1'b0;
	logic rst;
	row_t drv;
	fetch_pkg::line_t fill_line;
	fetch_pkg::fetch_bundle_t bundle;
	row_t tbl [NROWS];
	integer seed = 7286;
	int errors = 0;
	int checks = 0;

	// ========================================
	// Reference model state
	// ========================================
	fetch_pkg::addr_t m_pc;
	fetch_pkg::bno_t m_bno;
	int m_warm;
	logic m_valid [LINES];
	// Each entry remembers the full line address it was filled from
	fetch_pkg::addr_t m_ladr [LINES];
	fetch_pkg::line_t m_line [LINES];
	fetch_pkg::fetch_bundle_t exp_b;

	always #4 clk = ~clk;

	fetch_top #(
		.RST_PC(RST_PC),
		.LINES(LINES),
		.WARMUP(WARMUP)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.en_i(drv.en),
		.stall_i(drv.stall),
		.redirect_i(drv.redirect),
		.mc_active_i(drv.mc_active),
		.nmi_i(drv.nmi),
		.stomp_i(drv.stomp),
		.fill_i(drv.fill),
		.redirect_pc_i(drv.redirect_pc),
		.mc_adr_i(drv.mc_adr),
		.fill_adr_i(drv.fill_adr),
		.stomp_bno_i(drv.stomp_bno),
		.uop_num_i(drv.uop_num),
		.fill_line_i(fill_line),
		.bundle_o(bundle)
	);

	bind fetch_stage fetch_assertions u_assert (
		.clk(clk),
		.rst(rst),
		.stall_i(stall_i),
		.hit_i(hit_i),
		.warm_i(warm),
		.advance_i(advance_o),
		.line_i(line_i),
		.bundle_i(bundle_o)
	);

	// ========================================
	// Compare tasks
	// ========================================
	task automatic check_line(input string name, input fetch_pkg::line_t got, exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_pcs(input string name, input fetch_pkg::slot_pcs_t got, exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bno(input string name, input fetch_pkg::bno_t got, exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_uop(input string name, input fetch_pkg::uop_t got, exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_bundle();
		check_pcs("bundle.pcs", bundle.pcs, exp_b.pcs);
		check_line("bundle.line", bundle.line, exp_b.line);
		check_bno("bundle.bno", bundle.bno, exp_b.bno);
		check_uop("bundle.uop_num", bundle.uop_num, exp_b.uop_num);
		check_flag("bundle.mc_active", bundle.mc_active, exp_b.mc_active);
	endtask

	// ========================================
	// Reference model
	// ========================================
	task automatic model_reset();
		m_pc = RST_PC;
		m_bno = 5'd1;
		m_warm = 0;
		foreach (m_valid[k]) m_valid[k] = 1'b0;
		exp_b.pcs = {RST_PC + 32'd12, RST_PC + 32'd8, RST_PC + 32'd4, RST_PC};
		exp_b.line = fetch_pkg::NOP_LINE;
		exp_b.bno = 5'd1;
		exp_b.uop_num = '0;
		exp_b.mc_active = 1'b0;
	endtask

	// Works out what the coming clock edge does to the model
	task automatic model_step(input row_t r, input fetch_pkg::line_t fl);
		fetch_pkg::addr_t adr;
		int idx;
		logic hit;
		logic take;
		adr = r.mc_active ? r.mc_adr : m_pc;
		idx = int'((adr >> 4) % LINES);
		hit = m_valid[idx] && (m_ladr[idx] == (adr >> 4));
		// A real line needs warm-up done, a hit, no NMI and no foreign stomp
		take = (m_warm >= WARMUP) && hit && !r.nmi && !(r.stomp && r.stomp_bno != m_bno);
		if (r.en && !r.stall) begin
			exp_b.pcs.pc0 = adr;
			exp_b.pcs.pc1 = r.mc_active ? adr : adr + 32'd4;
			exp_b.pcs.pc2 = r.mc_active ? adr : adr + 32'd8;
			exp_b.pcs.pc3 = r.mc_active ? adr : adr + 32'd12;
			exp_b.line = take ? m_line[idx] : fetch_pkg::NOP_LINE;
			exp_b.bno = m_bno;
			exp_b.uop_num = r.uop_num;
			exp_b.mc_active = r.mc_active;
		end
		if (r.redirect) begin
			m_pc = r.redirect_pc - (r.redirect_pc % 16);
			m_bno++;
		end else if (r.en && !r.stall && take && !r.mc_active) begin
			m_pc = m_pc + 32'd16;
		end
		if (m_warm < WARMUP) m_warm++;
		// The fill lands after the lookup above, so it shows a cycle later
		if (r.fill) begin
			idx = int'((r.fill_adr >> 4) % LINES);
			m_valid[idx] = 1'b1;
			m_ladr[idx] = r.fill_adr >> 4;
			m_line[idx] = fl;
		end
	endtask

	// Columns are en, stall, redirect, redirect pc, fill, fill address,
	// nmi, stomp, stomp bno, mc_active, mc address and uop number
	task automatic load_table();
		tbl[0]  = '{'1, '0, '0, '0, '1, 32'h1000, '0, '0, '0, '0, '0, '0};
		tbl[1]  = '{'1, '0, '0, '0, '1, 32'h1010, '0, '0, '0, '0, '0, '0};
		tbl[2]  = '{'1, '0, '0, '0, '1, 32'h1020, '0, '0, '0, '0, '0, '0};
		tbl[3]  = '{'1, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0};
		tbl[4]  = '{'1, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0};
		tbl[5]  = '{'1, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0};
		tbl[6]  = '{'1, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0};
		// Miss on 0x1030 while it is being filled
		tbl[7]  = '{'1, '0, '0, '0, '1, 32'h1030, '0, '0, '0, '0, '0, '0};
		tbl[8]  = '{'1, '0, '0, '0, '1, 32'h1040, '0, '0, '0, '0, '0, '0};
		tbl[9]  = '{'1, '1, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0};
		tbl[10] = '{'1, '1, '1, 32'h2054, '1, 32'h2050, '0, '0, '0, '0, '0, '0};
		tbl[11] = '{'1, '0, '0, '0, '1, 32'h2060, '0, '0, '0, '0, '0, '0};
		tbl[12] = '{'1, '0, '0, '0, '1, 32'h2070, '0, '1, 5'd2, '0, '0, '0};
		tbl[13] = '{'1, '0, '0, '0, '0, '0, '0, '1, 5'd1, '0, '0, '0};
		tbl[14] = '{'1, '0, '0, '0, '0, '0, '1, '0, '0, '0, '0, '0};
		tbl[15] = '{'1, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0};
		tbl[16] = '{'1, '0, '0, '0, '0, '0, '0, '0, '0, '1, 32'h3008, 3'd3};
		tbl[17] = '{'1, '0, '0, '0, '0, '0, '0, '0, '0, '1, 32'h300c, 3'd4};
		tbl[18] = '{'0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0};
		tbl[19] = '{'1, '0, '1, 32'h1000, '0, '0, '0, '0, '0, '0, '0, '0};
		tbl[20] = '{'1, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0};
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		int row_errors;
		fetch_pkg::line_t fl;
		rst = 1'b1;
		drv = '0;
		fill_line = '0;
		load_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		model_reset();
		compare_bundle();
		$display("reset: %s", errors == 0 ? "ok" : "failed");
		for (int i = 0; i < NROWS; i++) begin
			row_errors = errors;
			fl = {$random(seed), $random(seed), $random(seed), $random(seed)};
			drv = tbl[i];
			fill_line = fl;
			model_step(tbl[i], fl);
			@(negedge clk);
			compare_bundle();
			$display("row %0d: %s", i, errors == row_errors ? "ok" : "failed");
		end
		$display("%0d rows, %0d checks, %0d errors", NROWS, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before all rows were applied", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/fetch_assertions.sv */
// ========================================
// Concurrent checks on the fetch stage
// Bound into every fetch_stage instance from the testbench
// ========================================
`timescale 1ns/100ps
`default_nettype none

module fetch_assertions (
	input logic                      clk,
	input logic                      rst,
	input logic                      stall_i,
	input logic                      hit_i,
	input logic                      warm_i,
	input logic                      advance_i,
	input fetch_pkg::line_t          line_i,
	input fetch_pkg::fetch_bundle_t  bundle_i
);

	// The PC only steps past a line that really came out of the cache,
	// and that very line lands in the bundle on the next cycle
	advance_hit: assert property (@(posedge clk) disable iff (rst)
		advance_i |-> hit_i ##1 (bundle_i.line == $past(line_i)))
		else $error("advance without the cache line landing in the bundle");

	// Only no-op lines leave the stage until warm-up is over
	warm_nop: assert property (@(posedge clk) disable iff (rst)
		warm_i |-> bundle_i.line == fetch_pkg::NOP_LINE)
		else $error("bundle line is not the no-op line during warm-up");

	// A stall freezes the whole bundle for the next cycle
	stall_hold: assert property (@(posedge clk) disable iff (rst) stall_i |=> $stable(bundle_i))
		else $error("bundle changed across a stall");

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
// ========================================
// Fetch front end top level
// Connects the PC generator, line cache and fetch stage, and
// hands its parameters down to them
// ========================================
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
	parameter fetch_pkg::addr_t RST_PC = 32'h0000_1000,
	parameter int unsigned LINES = 8,
	parameter int unsigned WARMUP = 4
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      en_i,
	input  logic                      stall_i,
	input  logic                      redirect_i,
	input  logic                      mc_active_i,
	input  logic                      nmi_i,
	input  logic                      stomp_i,
	input  logic                      fill_i,
	input  fetch_pkg::addr_t          redirect_pc_i,
	input  fetch_pkg::addr_t          mc_adr_i,
	input  fetch_pkg::addr_t          fill_adr_i,
	input  fetch_pkg::bno_t           stomp_bno_i,
	input  fetch_pkg::uop_t           uop_num_i,
	input  fetch_pkg::line_t          fill_line_i,
	output fetch_pkg::fetch_bundle_t  bundle_o
);

	fetch_pkg::addr_t fetch_adr;
	fetch_pkg::slot_pcs_t slot_pcs;
	fetch_pkg::bno_t bno;
	fetch_pkg::line_t line;
	logic hit;
	logic advance;

	// Address generation, steps when the stage accepts a real line
	fetch_pc_gen #(
		.RST_PC(RST_PC)
	) u_pc_gen (
		.clk(clk),
		.rst(rst),
		.advance_i(advance),
		.redirect_i(redirect_i),
		.mc_active_i(mc_active_i),
		.redirect_pc_i(redirect_pc_i),
		.mc_adr_i(mc_adr_i),
		.fetch_adr_o(fetch_adr),
		.slot_pcs_o(slot_pcs),
		.bno_o(bno)
	);

	// Line lookup on the same address in the same cycle
	fetch_line_cache #(
		.LINES(LINES)
	) u_cache (
		.clk(clk),
		.rst(rst),
		.rd_adr_i(fetch_adr),
		.line_o(line),
		.hit_o(hit),
		.fill_i(fill_i),
		.fill_adr_i(fill_adr_i),
		.fill_line_i(fill_line_i)
	);

	fetch_stage #(
		.RST_PC(RST_PC),
		.WARMUP(WARMUP)
	) u_stage (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.stall_i(stall_i),
		.hit_i(hit),
		.nmi_i(nmi_i),
		.stomp_i(stomp_i),
		.mc_active_i(mc_active_i),
		.stomp_bno_i(stomp_bno_i),
		.bno_i(bno),
		.slot_pcs_i(slot_pcs),
		.line_i(line),
		.uop_num_i(uop_num_i),
		.advance_o(advance),
		.bundle_o(bundle_o)
	);

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
// ========================================
// Fetch pipeline register
// Merges the slot addresses with the cache line into one bundle
// and swaps in a no-op line on a miss, during warm-up, on an NMI
// or when the line belongs to a stomped branch path
// ========================================
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
	parameter fetch_pkg::addr_t RST_PC = 32'h0000_1000,
	parameter int unsigned WARMUP = 4
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      en_i,
	input  logic                      stall_i,
	input  logic                      hit_i,
	input  logic                      nmi_i,
	input  logic                      stomp_i,
	input  logic                      mc_active_i,
	input  fetch_pkg::bno_t           stomp_bno_i,
	input  fetch_pkg::bno_t           bno_i,
	input  fetch_pkg::slot_pcs_t      slot_pcs_i,
	input  fetch_pkg::line_t          line_i,
	input  fetch_pkg::uop_t           uop_num_i,
	output logic                      advance_o,
	output fetch_pkg::fetch_bundle_t  bundle_o
);

	// One spare count so the width stays valid even with no warm-up
	localparam int unsigned CNT_W = $clog2(WARMUP + 2);

	// Slot addresses the bundle holds straight out of reset
	localparam fetch_pkg::slot_pcs_t RST_PCS = '{
		pc3: RST_PC + 32'd12,
		pc2: RST_PC + 32'd8,
		pc1: RST_PC + 32'd4,
		pc0: RST_PC
	};

	logic [CNT_W-1:0] warm_cnt_q;
	logic warm;
	logic step;
	logic stomped;
	logic take_line;
	fetch_pkg::fetch_bundle_t bundle_q;

	// ========================================
	// Warm-up counter
	// ========================================

	// Counts clock cycles after reset and parks at WARMUP
	always_ff @(posedge clk) begin
		if (rst) begin
			warm_cnt_q <= '0;
		end else if (warm) begin
			warm_cnt_q <= warm_cnt_q + 1'b1;
		end
	end

	// ========================================
	// Capture decision
	// ========================================

	always_comb begin
		warm = warm_cnt_q < CNT_W'(WARMUP);
		step = en_i && !stall_i;
		// A stomp only kills lines fetched on a different branch path
		stomped = stomp_i && (stomp_bno_i != bno_i);
		take_line = !warm && hit_i && !nmi_i && !stomped;
		advance_o = step && take_line;
	end

	// ========================================
	// Bundle register
	// ========================================

	// Everything holds while stalled, the line is replaced by no-ops
	// whenever it cannot be used
	always_ff @(posedge clk) begin
		if (rst) begin
			bundle_q.pcs <= RST_PCS;
			bundle_q.line <= fetch_pkg::NOP_LINE;
			bundle_q.bno <= 5'd1;
			bundle_q.uop_num <= '0;
			bundle_q.mc_active <= 1'b0;
		end else if (step) begin
			bundle_q.pcs <= slot_pcs_i;
			bundle_q.line <= take_line ? line_i : fetch_pkg::NOP_LINE;
			bundle_q.bno <= bno_i;
			bundle_q.uop_num <= uop_num_i;
			bundle_q.mc_active <= mc_active_i;
		end
	end

	assign bundle_o = bundle_q;

endmodule

`default_nettype wire

/* hdl/fetch_line_cache.sv */
// ========================================
// Direct-mapped instruction line store
// Read is combinational on rd_adr_i; lines are written through
// the fill port and show up the cycle after the fill edge
// ========================================
`timescale 1ns/100ps
`default_nettype none

module fetch_line_cache #(
	parameter int unsigned LINES = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  fetch_pkg::addr_t  rd_adr_i,
	output fetch_pkg::line_t  line_o,
	output logic              hit_o,
	input  logic              fill_i,
	input  fetch_pkg::addr_t  fill_adr_i,
	input  fetch_pkg::line_t  fill_line_i
);

	// Address split: byte offset, entry index, then the tag above it
	localparam int unsigned OFS_W = $clog2(fetch_pkg::LINE_BYTES);
	localparam int unsigned IDX_W = $clog2(LINES);
	localparam int unsigned TAG_W = 32 - OFS_W - IDX_W;

	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [TAG_W-1:0] tag_t;

	logic [LINES-1:0] valid_q;
	tag_t tag_q [LINES];
	fetch_pkg::line_t line_q [LINES];

	idx_t rd_idx;
	tag_t rd_tag;
	idx_t fill_idx;
	tag_t fill_tag;

	// ========================================
	// Address decode
	// ========================================

	always_comb begin
		rd_idx = rd_adr_i[OFS_W +: IDX_W];
		rd_tag = rd_adr_i[31 -: TAG_W];
		fill_idx = fill_adr_i[OFS_W +: IDX_W];
		fill_tag = fill_adr_i[31 -: TAG_W];
	end

	// ========================================
	// Storage
	// ========================================

	// Every entry misses after reset until it is filled
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (fill_i) begin
			valid_q[fill_idx] <= 1'b1;
		end
	end

	// Tag and data arrays are written together on a fill
	always_ff @(posedge clk) begin
		if (fill_i) begin
			tag_q[fill_idx] <= fill_tag;
			line_q[fill_idx] <= fill_line_i;
		end
	end

	// ========================================
	// Lookup
	// ========================================

	// The line is driven out whether or not it hits; the fetch stage
	// decides what to do with a miss
	always_comb begin
		line_o = line_q[rd_idx];
		hit_o = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
	end

endmodule

`default_nettype wire

/* hdl/fetch_pc_gen.sv */
// ========================================
// Fetch address generator
// Holds the line PC and the branch path number, and forms the
// address sent to the line cache plus the four slot addresses
// ========================================
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_gen #(
	parameter fetch_pkg::addr_t RST_PC = 32'h0000_1000
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  advance_i,
	input  logic                  redirect_i,
	input  logic                  mc_active_i,
	input  fetch_pkg::addr_t      redirect_pc_i,
	input  fetch_pkg::addr_t      mc_adr_i,
	output fetch_pkg::addr_t      fetch_adr_o,
	output fetch_pkg::slot_pcs_t  slot_pcs_o,
	output fetch_pkg::bno_t       bno_o
);

	// Mask that clears the byte offset within a line
	localparam fetch_pkg::addr_t LINE_MASK = ~fetch_pkg::addr_t'(fetch_pkg::LINE_BYTES - 1);

	fetch_pkg::addr_t pc_q;
	fetch_pkg::bno_t bno_q;
	fetch_pkg::addr_t adr;

	// ========================================
	// Line PC and branch number
	// ========================================

	// A redirect wins over a sequential step and is taken even when the
	// pipeline is stalled, since advance is already gated by the stall
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= RST_PC;
			bno_q <= 5'd1;
		end else if (redirect_i) begin
			pc_q <= redirect_pc_i & LINE_MASK;
			bno_q <= bno_q + 5'd1;
		end else if (advance_i && !mc_active_i) begin
			// While micro-code owns the address the line PC keeps its place
			pc_q <= pc_q + fetch_pkg::addr_t'(fetch_pkg::LINE_BYTES);
		end
	end

	// ========================================
	// Address select and slot addresses
	// ========================================

	// Micro-code takes over the fetch address outright
	always_comb begin
		adr = mc_active_i ? mc_adr_i : pc_q;
	end

	// In micro-code mode all slots point at the same micro-code address,
	// otherwise they step one word apart through the line
	always_comb begin
		slot_pcs_o.pc0 = adr;
		slot_pcs_o.pc1 = mc_active_i ? adr : adr + 32'd4;
		slot_pcs_o.pc2 = mc_active_i ? adr : adr + 32'd8;
		slot_pcs_o.pc3 = mc_active_i ? adr : adr + 32'd12;
	end

	assign fetch_adr_o = adr;
	assign bno_o = bno_q;

endmodule

`default_nettype wire

/* hdl/fetch_pkg.sv */
// ========================================
// Shared types and constants of the fetch front end
// Every fetch block refers to these by scoped name, so compile
// this package before any of the modules
// ========================================
`default_nettype none

package fetch_pkg;

	// ========================================
	// Widths that carry a meaning
	// ========================================

	// Instruction byte address
	typedef logic [31:0] addr_t;

	// One instruction word
	typedef logic [31:0] instr_t;

	// Four instructions per line, slot 0 sits in the low word
	typedef logic [127:0] line_t;

	// Branch path number, bumped on every redirect
	typedef logic [4:0] bno_t;

	// Micro-op index within a micro-code sequence
	typedef logic [2:0] uop_t;

	// ========================================
	// Constants
	// ========================================

	// Word placed in every slot of a suppressed line
	localparam instr_t OP_NOP = 32'h0000_0013;
	localparam line_t NOP_LINE = {4{OP_NOP}};

	// Byte stride from one line to the next
	localparam int unsigned LINE_BYTES = 16;

	// One address per slot, pc0 in the low bits like the line
	typedef struct packed {
		addr_t pc3;
		addr_t pc2;
		addr_t pc1;
		addr_t pc0;
	} slot_pcs_t;

	// Registered output of the fetch stage, 265 bits
	typedef struct packed {
		slot_pcs_t pcs;
		line_t line;
		bno_t bno;
		uop_t uop_num;
		logic mc_active;
	} fetch_bundle_t;

endpackage

`default_nettype wire
